// File: filelist.f
cpu_pkg.sv
cpu_ifs.sv
register_file.sv
control_unit.sv
alu.sv
hazard_unit.sv
forward_unit.sv
datapath.sv
cpu_top.sv
tb_cpu.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = tb_cpu
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG) || ! grep -qF '** PASS **' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: tb_cpu.sv
/*
  testbench for the pipelined core
  memory model with lfsr wait states, program assembler,
  reference isa model, store monitor and test report
*/
module tb_cpu;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_pkg::*;

  localparam int HALT_TIMEOUT = 4000;  // cycles

  logic  CLK, nRST;
  logic  imemREN, dmemREN, dmemWEN, halt;
  word_t imemaddr, imemload, dmemaddr, dmemstore, dmemload;

  logic        ihit = 1'b0;
  logic        dhit = 1'b0;
  logic [1:0]  icnt = 2'd0;
  logic [1:0]  dcnt = 2'd0;
  logic [15:0] lfsr = 16'd54376;
  logic        ipend = 1'b0;
  logic        dpend = 1'b0;
  logic        waits;
  word_t       ipend_addr, dpend_addr, dpend_data;

  word_t imem [64];
  word_t dmem [64];
  word_t ref_mem [64];
  word_t exp_addr [$];
  word_t exp_data [$];
  int    stores_seen, store_base;
  int    errors, mon_errs, mem_errs, passed, failed;

  cpu_top UUT (.*);

  assign imemload = imem[imemaddr[7:2]];
  assign dmemload = dmem[dmemaddr[7:2]];

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11
  endfunction

  function automatic logic [1:0] draw_wait();
    logic [1:0] v;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  function automatic word_t fill_word(input int i);
    word_t a;
    a = word_t'(i) << 2;
    return {a[15:0], a[31:16]} ^ a ^ 32'h5eed_0000;
  endfunction

  function automatic word_t rtype(input funct_t fn, input regbits_t rd, rs, rt,
                                  input logic [4:0] sh);
    return {RTYPE, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t itype(input opcode_t op, input regbits_t rt, rs,
                                  input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic int total_errors();
    return errors + mon_errs + mem_errs;
  endfunction

  task automatic compare(input string name, input word_t exp, input word_t act,
                         inout int errs);
    if (exp !== act) begin
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
      errs++;
    end
  endtask

  // memory model, hits after 0..3 wait cycles
  always @(posedge CLK) begin
    logic [1:0] d;
    if (nRST) compare("imemREN", 32'd1, word_t'(imemREN), mem_errs);  // fetch always up
    if (nRST && ipend && imemaddr !== ipend_addr) begin
      $display("fetch address moved from %h to %h before its hit at %0t",
               ipend_addr, imemaddr, $time);
      mem_errs++;
    end
    if (nRST && dpend && (dmemaddr !== dpend_addr || dmemstore !== dpend_data)) begin
      $display("data request at %h changed before its hit at %0t", dpend_addr, $time);
      mem_errs++;
    end
    ipend      = nRST && imemREN && !ihit;
    ipend_addr = imemaddr;
    dpend      = nRST && (dmemREN || dmemWEN) && !dhit;
    dpend_addr = dmemaddr;
    dpend_data = dmemstore;

    if (!imemREN || ihit) begin  // new wait count once a hit is taken
      d = waits ? draw_wait() : 2'd0;
      icnt <= d;
      ihit <= (d == 2'd0);
    end else if (icnt > 2'd1) begin
      icnt <= icnt - 2'd1;
    end else begin
      ihit <= 1'b1;
    end

    if (!(dmemREN || dmemWEN) || dhit) begin
      d = waits ? draw_wait() : 2'd0;
      dcnt <= d;
      dhit <= (d == 2'd0);
    end else if (dcnt > 2'd1) begin
      dcnt <= dcnt - 2'd1;
    end else begin
      dhit <= 1'b1;
    end

    if (!nRST) begin
      for (int i = 0; i < 64; i++) dmem[i] <= fill_word(i);  // image restored
    end else if (dmemWEN && dhit) begin
      dmem[dmemaddr[7:2]] <= dmemstore;
    end
  end

  // store monitor, in program order
  always @(posedge CLK) begin
    if (nRST && dmemWEN && dhit) begin
      if (stores_seen - store_base < exp_addr.size()) begin
        compare("dmemaddr", exp_addr[stores_seen - store_base], dmemaddr, mon_errs);
        compare("dmemstore", exp_data[stores_seen - store_base], dmemstore, mon_errs);
      end else begin
        $display("unexpected store of %h to %h at %0t", dmemstore, dmemaddr, $time);
        mon_errs++;
      end
      stores_seen++;
    end
  end

  // sequential isa model of the program in imem
  function automatic void run_ref();
    word_t    r [32];
    word_t    pc, ins, a, b, simm, ea;
    regbits_t rd, rt;
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < 64; i++) ref_mem[i] = fill_word(i);
    exp_addr.delete();
    exp_data.delete();
    pc = PC_INIT;
    for (int s = 0; s < 4000; s++) begin
      ins  = imem[pc[7:2]];
      a    = r[ins[25:21]];
      b    = r[ins[20:16]];
      rt   = ins[20:16];
      rd   = ins[15:11];
      simm = {{16{ins[15]}}, ins[15:0]};
      ea   = a + simm;
      pc   = pc + 32'd4;
      case (ins[31:26])
        RTYPE: begin
          case (ins[5:0])
            SLL:     r[rd] = b << ins[10:6];
            ADDU:    r[rd] = a + b;
            SUBU:    r[rd] = a - b;
            AND:     r[rd] = a & b;
            OR:      r[rd] = a | b;
            SLT:     r[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: ;
          endcase
        end
        ADDIU: r[rt] = ea;
        ORI:   r[rt] = a | {16'b0, ins[15:0]};
        LUI:   r[rt] = {ins[15:0], 16'b0};
        LW:    r[rt] = ref_mem[ea[7:2]];
        SW: begin
          ref_mem[ea[7:2]] = b;
          exp_addr.push_back(ea);
          exp_data.push_back(b);
        end
        BEQ:   if (a == b) pc = pc + {simm[29:0], 2'b00};
        BNE:   if (a != b) pc = pc + {simm[29:0], 2'b00};
        J:     pc = {pc[31:28], ins[25:0], 2'b00};
        HALT:  return;
        default: ;
      endcase
      r[0] = '0;
    end
  endfunction

  task automatic apply_reset(input bit check_idle);
    @(posedge CLK);
    nRST <= 1'b0;
    repeat (7) @(posedge CLK);
    @(negedge CLK);
    if (check_idle) begin
      compare("halt", 32'd0, word_t'(halt), errors);
      compare("dmemREN", 32'd0, word_t'(dmemREN), errors);
      compare("dmemWEN", 32'd0, word_t'(dmemWEN), errors);
      compare("imemaddr", PC_INIT, imemaddr, errors);
    end
    @(posedge CLK);
    nRST <= 1'b1;
  endtask

  task automatic report_test(input int num, input string name, input int err0);
    if (total_errors() == err0) begin
      passed++;
      $display("test %0d %s: passed", num, name);
    end else begin
      failed++;
      $display("test %0d %s: failed with %0d errors", num, name, total_errors() - err0);
    end
  endtask

  task automatic run_program(input int num, input string name, input bit use_waits);
    int n;
    int err0;
    err0       = total_errors();
    waits      = use_waits;
    run_ref();
    store_base = stores_seen;
    apply_reset(1'b0);
    n = 0;
    while (!halt && n < HALT_TIMEOUT) begin
      @(negedge CLK);
      n++;
    end
    if (!halt) begin
      $display("halt did not rise within %0d cycles in %s", HALT_TIMEOUT, name);
      errors++;
    end
    repeat (4) begin  // halt must hold
      @(negedge CLK);
      compare("halt", 32'd1, word_t'(halt), errors);
    end
    compare("store count", word_t'(exp_addr.size()), word_t'(stores_seen - store_base),
            errors);
    for (int i = 0; i < 64; i++) begin
      compare($sformatf("dmem[%0d]", i), ref_mem[i], dmem[i], errors);
    end
    report_test(num, name, err0);
  endtask

  task automatic alu_program();
    for (int i = 0; i < 64; i++) imem[i] = '0;
    imem[0]  = itype(ORI, 1, 0, 16'h0040);    // store base
    imem[1]  = itype(ADDIU, 2, 0, 16'd5);
    imem[2]  = itype(ADDIU, 3, 0, 16'hfffd);
    imem[3]  = rtype(ADDU, 4, 2, 3, 0);       // r3 from mem, r2 from wb
    imem[4]  = rtype(SUBU, 5, 4, 2, 0);
    imem[5]  = rtype(SLT, 6, 3, 2, 0);        // -3 < 5
    imem[6]  = rtype(SLT, 7, 2, 5, 0);
    imem[7]  = rtype(SLL, 8, 0, 2, 4);
    imem[8]  = itype(LUI, 9, 0, 16'h1234);
    imem[9]  = itype(ORI, 9, 9, 16'h5678);
    imem[10] = rtype(AND, 10, 9, 8, 0);
    imem[11] = rtype(OR, 11, 10, 3, 0);
    imem[12] = itype(SW, 11, 1, 16'd28);      // store data forwarded
    imem[13] = itype(SW, 4, 1, 16'd0);
    imem[14] = itype(SW, 5, 1, 16'd4);
    imem[15] = itype(SW, 6, 1, 16'd8);
    imem[16] = itype(SW, 7, 1, 16'd12);
    imem[17] = itype(SW, 8, 1, 16'd16);
    imem[18] = itype(SW, 9, 1, 16'd20);
    imem[19] = itype(SW, 10, 1, 16'd24);
    imem[20] = {HALT, 26'b0};
  endtask

  task automatic load_use_program();
    for (int i = 0; i < 64; i++) imem[i] = '0;
    imem[0] = itype(ORI, 1, 0, 16'h0040);
    imem[1] = itype(LW, 2, 1, 16'd8);
    imem[2] = rtype(ADDU, 3, 2, 1, 0);        // needs the load at once
    imem[3] = itype(SW, 3, 1, 16'd0);
    imem[4] = itype(LW, 4, 1, 16'd12);
    imem[5] = itype(SW, 4, 1, 16'd4);
    imem[6] = {HALT, 26'b0};
  endtask

  task automatic control_program();
    for (int i = 0; i < 64; i++) imem[i] = '0;
    imem[0]  = itype(ORI, 1, 0, 16'h0040);
    imem[1]  = itype(ADDIU, 2, 0, 16'd3);     // loop count
    imem[2]  = itype(BEQ, 0, 0, 16'd1);       // taken
    imem[3]  = itype(SW, 2, 1, 16'd0);        // shadow slot
    imem[4]  = itype(BNE, 0, 0, 16'd1);       // not taken
    imem[5]  = itype(SW, 2, 1, 16'd4);
    imem[6]  = itype(ADDIU, 2, 2, 16'hffff);
    imem[7]  = itype(SW, 2, 1, 16'd8);
    imem[8]  = itype(BNE, 0, 2, 16'hfffd);    // back to 6
    imem[9]  = {J, 26'd11};
    imem[10] = itype(SW, 1, 1, 16'd12);       // shadow slot
    imem[11] = itype(SW, 2, 1, 16'd16);
    imem[12] = {HALT, 26'b0};
  endtask

  initial begin
    int err0;
    nRST       = 1'b0;
    waits      = 1'b0;
    errors     = 0;
    passed     = 0;
    failed     = 0;
    store_base = 0;
    for (int i = 0; i < 64; i++) imem[i] = '0;
    err0 = total_errors();
    apply_reset(1'b1);
    report_test(1, "reset state", err0);
    alu_program();
    run_program(2, "alu and forwarding", 1'b0);
    load_use_program();
    run_program(3, "load-use", 1'b0);
    control_program();
    run_program(4, "branches and jump", 1'b0);
    alu_program();
    run_program(5, "wait states", 1'b1);
    $display("tests passed %0d, failed %0d", passed, failed);
    if (failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: cpu_top.sv
/*
  processor top level
  plain instruction and data memory ports around the datapath
*/
module cpu_top (
  input  logic           CLK,
  input  logic           nRST,
  output logic           imemREN,
  output cpu_pkg::word_t imemaddr,
  input  cpu_pkg::word_t imemload,
  input  logic           ihit,
  output logic           dmemREN,
  output logic           dmemWEN,
  output cpu_pkg::word_t dmemaddr,
  output cpu_pkg::word_t dmemstore,
  input  cpu_pkg::word_t dmemload,
  input  logic           dhit,
  output logic           halt
);

  datapath DP (
    .CLK       (CLK),
    .nRST      (nRST),
    .imemREN   (imemREN),
    .imemaddr  (imemaddr),
    .imemload  (imemload),
    .ihit      (ihit),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .dmemload  (dmemload),
    .dhit      (dhit),
    .halt      (halt)
  );

endmodule

// File: datapath.sv
/*
  five-stage pipeline datapath
  pc, if/id, id/ex, ex/mem, mem/wb registers, decode branch resolve,
  forwarding muxes, writeback mux, memory-stall freeze, halt
*/
module datapath (
  input  logic           CLK,
  input  logic           nRST,
  output logic           imemREN,
  output cpu_pkg::word_t imemaddr,
  input  cpu_pkg::word_t imemload,
  input  logic           ihit,
  output logic           dmemREN,
  output logic           dmemWEN,
  output cpu_pkg::word_t dmemaddr,
  output cpu_pkg::word_t dmemstore,
  input  cpu_pkg::word_t dmemload,
  input  logic           dhit,
  output logic           halt
);
  import cpu_pkg::*;

  typedef struct packed {
    word_t instr;
    word_t pc4;
  } ifid_t;

  typedef struct packed {
    aluop_t   alu_op;
    logic     alu_src_imm;
    logic     shift_src;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     halt;
    wbsrc_t   wb_src;
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm;
    regbits_t rs;
    regbits_t rt;
    regbits_t wsel;
  } idex_t;

  typedef struct packed {
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     halt;
    wbsrc_t   wb_src;
    word_t    alu_out;
    word_t    store_data;
    regbits_t wsel;
  } exmem_t;

  typedef struct packed {
    logic     reg_write;
    wbsrc_t   wb_src;
    word_t    alu_out;
    word_t    load_data;
    regbits_t wsel;
  } memwb_t;

  register_file_if rfif();
  forward_unit_if  fwif();
  hazard_unit_if   hzif();

  word_t  pc, pc_plus4, br_target, jmp_target;
  ifid_t  ifid;
  idex_t  idex;
  exmem_t exmem;
  memwb_t memwb;
  logic   freeze, fetch_done, halt_q;
  logic   dmem_done;  // data access served while fetch still waits
  word_t  load_q;

  aluop_t cu_alu_op;
  wbsrc_t cu_wb_src;
  word_t  cu_imm;
  logic   cu_alu_src_imm, cu_shift_src, cu_reg_dst_rd, cu_reg_write;
  logic   cu_mem_read, cu_mem_write, cu_branch, cu_branch_neq, cu_jump, cu_halt;

  word_t  fwd_a_val, fwd_b_val, alu_a, alu_b, alu_result, wb_data;

  register_file RF (.CLK(CLK), .nRST(nRST), .rfif(rfif));
  forward_unit  FWU (.fwif(fwif));
  hazard_unit   HZU (.hzif(hzif));

  control_unit CU (
    .instr(ifid.instr), .alu_op(cu_alu_op), .alu_src_imm(cu_alu_src_imm),
    .shift_src(cu_shift_src), .reg_dst_rd(cu_reg_dst_rd), .reg_write(cu_reg_write),
    .mem_read(cu_mem_read), .mem_write(cu_mem_write), .branch(cu_branch),
    .branch_neq(cu_branch_neq), .jump(cu_jump), .halt(cu_halt),
    .wb_src(cu_wb_src), .imm_ext(cu_imm)
  );

  alu ALU (
    .alu_op(idex.alu_op), .port_a(alu_a), .port_b(alu_b),
    .result(alu_result), .zero()
  );

  // whole pipeline holds on a missing fetch or a pending data access
  assign freeze = !ihit || ((dmemREN || dmemWEN) && !dhit);

  // fetch
  assign imemREN  = 1'b1;
  assign imemaddr = pc;
  assign pc_plus4 = pc + 32'd4;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (!freeze && hzif.pc_en && !cu_halt && !fetch_done) begin
      if (hzif.flush_ifid) pc <= cu_jump ? jmp_target : br_target;
      else pc <= pc_plus4;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifid <= '0;
    end else if (!freeze && hzif.ifid_en) begin
      if (hzif.flush_ifid || cu_halt || fetch_done) ifid <= '0;  // bubble
      else ifid <= '{instr: imemload, pc4: pc_plus4};
    end
  end

  // no fetches past a halt once it leaves decode
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) fetch_done <= 1'b0;
    else if (!freeze && cu_halt && !hzif.flush_idex) fetch_done <= 1'b1;
  end

  // decode
  assign rfif.rsel1 = ifid.instr[25:21];
  assign rfif.rsel2 = ifid.instr[20:16];
  assign br_target  = ifid.pc4 + {cu_imm[29:0], 2'b00};
  assign jmp_target = {ifid.pc4[31:28], ifid.instr[25:0], 2'b00};

  assign hzif.id_rs         = ifid.instr[25:21];
  assign hzif.id_rt         = ifid.instr[20:16];
  assign hzif.id_branch     = cu_branch;
  assign hzif.id_branch_neq = cu_branch_neq;
  assign hzif.id_jump       = cu_jump;
  assign hzif.is_equal      = (rfif.rdat1 == rfif.rdat2);
  assign hzif.ex_mem_read   = idex.mem_read;
  assign hzif.ex_reg_write  = idex.reg_write;
  assign hzif.ex_rd         = idex.wsel;
  assign hzif.mem_reg_write = exmem.reg_write;
  assign hzif.mem_rd        = exmem.wsel;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      idex <= '0;
    end else if (!freeze) begin
      if (hzif.flush_idex) begin
        idex <= '0;
      end else begin
        idex.alu_op      <= cu_alu_op;
        idex.alu_src_imm <= cu_alu_src_imm;
        idex.shift_src   <= cu_shift_src;
        idex.reg_write   <= cu_reg_write;
        idex.mem_read    <= cu_mem_read;
        idex.mem_write   <= cu_mem_write;
        idex.halt        <= cu_halt;
        idex.wb_src      <= cu_wb_src;
        idex.rdat1       <= rfif.rdat1;
        idex.rdat2       <= rfif.rdat2;
        idex.imm         <= cu_imm;
        idex.rs          <= ifid.instr[25:21];
        idex.rt          <= ifid.instr[20:16];
        idex.wsel        <= cu_reg_dst_rd ? ifid.instr[15:11] : ifid.instr[20:16];
      end
    end
  end

  // execute
  assign fwif.ex_rs         = idex.rs;
  assign fwif.ex_rt         = idex.rt;
  assign fwif.mem_rd        = exmem.wsel;
  assign fwif.mem_reg_write = exmem.reg_write;
  assign fwif.wb_rd         = memwb.wsel;
  assign fwif.wb_reg_write  = memwb.reg_write;

  always_comb begin
    case (fwif.fwd_a)
      FWD_MEM: fwd_a_val = exmem.alu_out;
      FWD_WB:  fwd_a_val = wb_data;
      default: fwd_a_val = idex.rdat1;
    endcase
    case (fwif.fwd_b)
      FWD_MEM: fwd_b_val = exmem.alu_out;
      FWD_WB:  fwd_b_val = wb_data;
      default: fwd_b_val = idex.rdat2;
    endcase
  end

  assign alu_a = idex.shift_src ? idex.imm : fwd_a_val;
  assign alu_b = idex.alu_src_imm ? idex.imm : fwd_b_val;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exmem <= '0;
    end else if (!freeze) begin
      exmem.reg_write  <= idex.reg_write;
      exmem.mem_read   <= idex.mem_read;
      exmem.mem_write  <= idex.mem_write;
      exmem.halt       <= idex.halt;
      exmem.wb_src     <= idex.wb_src;
      exmem.alu_out    <= alu_result;
      exmem.store_data <= fwd_b_val;  // forwarded store data
      exmem.wsel       <= idex.wsel;
    end
  end

  // memory
  assign dmemREN   = exmem.mem_read && !dmem_done;
  assign dmemWEN   = exmem.mem_write && !dmem_done;
  assign dmemaddr  = exmem.alu_out;
  assign dmemstore = exmem.store_data;

  // a data hit during a fetch wait ends the request, load data kept here
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dmem_done <= 1'b0;
      load_q    <= '0;
    end else if (!freeze) begin
      dmem_done <= 1'b0;
    end else if ((dmemREN || dmemWEN) && dhit) begin
      dmem_done <= 1'b1;
      load_q    <= dmemload;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      memwb <= '0;
    end else if (!freeze) begin
      memwb.reg_write <= exmem.reg_write;
      memwb.wb_src    <= exmem.wb_src;
      memwb.alu_out   <= exmem.alu_out;
      memwb.load_data <= dmem_done ? load_q : dmemload;
      memwb.wsel      <= exmem.wsel;
    end
  end

  // writeback
  assign wb_data   = (memwb.wb_src == WB_MEM) ? memwb.load_data : memwb.alu_out;
  assign rfif.wen  = memwb.reg_write;
  assign rfif.wsel = memwb.wsel;
  assign rfif.wdat = wb_data;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) halt_q <= 1'b0;
    else if (!freeze && exmem.halt) halt_q <= 1'b1;  // sticky
  end

  assign halt = halt_q;

  a_one_dmem_req: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmemREN && dmemWEN));

  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt && $stable(pc));

endmodule

// File: forward_unit.sv
/*
  forwarding unit
  execute operand selects from mem and wb, mem has priority
*/
module forward_unit (
  forward_unit_if.fu fwif
);
  import cpu_pkg::*;

  logic mem_ok, wb_ok;

  // r0 is never a forwarding source
  assign mem_ok = fwif.mem_reg_write && (fwif.mem_rd != '0);
  assign wb_ok  = fwif.wb_reg_write && (fwif.wb_rd != '0);

  always_comb begin
    if (mem_ok && fwif.mem_rd == fwif.ex_rs) fwif.fwd_a = FWD_MEM;
    else if (wb_ok && fwif.wb_rd == fwif.ex_rs) fwif.fwd_a = FWD_WB;
    else fwif.fwd_a = FWD_NONE;
  end

  always_comb begin
    if (mem_ok && fwif.mem_rd == fwif.ex_rt) fwif.fwd_b = FWD_MEM;
    else if (wb_ok && fwif.wb_rd == fwif.ex_rt) fwif.fwd_b = FWD_WB;
    else fwif.fwd_b = FWD_NONE;
  end

endmodule

// File: hazard_unit.sv
/*
  hazard detection
  load-use and branch operand stalls, branch/jump flush, pc enable
*/
module hazard_unit (
  hazard_unit_if.hu hzif
);
  logic ex_match, mem_match;
  logic load_use, branch_wait, stall, taken;

  // decode source matches a nonzero producer
  assign ex_match = (hzif.ex_rd != '0) &&
                    (hzif.ex_rd == hzif.id_rs || hzif.ex_rd == hzif.id_rt);
  assign mem_match = (hzif.mem_rd != '0) &&
                     (hzif.mem_rd == hzif.id_rs || hzif.mem_rd == hzif.id_rt);

  assign load_use = hzif.ex_mem_read && ex_match;

  // decode compare reads the register file, so wait for ex and mem producers
  assign branch_wait = hzif.id_branch &&
                       ((hzif.ex_reg_write && ex_match) ||
                        (hzif.mem_reg_write && mem_match));

  assign stall = load_use || branch_wait;
  assign taken = hzif.id_jump ||
                 (hzif.id_branch && (hzif.is_equal != hzif.id_branch_neq));

  assign hzif.pc_en      = !stall;
  assign hzif.ifid_en    = !stall;
  assign hzif.flush_idex = stall;             // bubble into execute
  assign hzif.flush_ifid = !stall && taken;

endmodule

// File: alu.sv
/*
  combinational alu
  add, sub, and, or, signed slt, sll, zero flag
*/
module alu (
  input  cpu_pkg::aluop_t alu_op,
  input  cpu_pkg::word_t  port_a,
  input  cpu_pkg::word_t  port_b,
  output cpu_pkg::word_t  result,
  output logic            zero
);
  import cpu_pkg::*;

  always_comb begin
    case (alu_op)
      ALU_SLL: result = port_b << port_a[4:0];  // port_a holds shamt
      ALU_ADD: result = port_a + port_b;
      ALU_SUB: result = port_a - port_b;
      ALU_AND: result = port_a & port_b;
      ALU_OR:  result = port_a | port_b;
      ALU_SLT: result = {31'b0, $signed(port_a) < $signed(port_b)};
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

// File: control_unit.sv
/*
  instruction decoder
  opcode and function to pipeline control fields, immediate extension
*/
module control_unit (
  input  cpu_pkg::word_t  instr,
  output cpu_pkg::aluop_t alu_op,
  output logic            alu_src_imm,
  output logic            shift_src,
  output logic            reg_dst_rd,
  output logic            reg_write,
  output logic            mem_read,
  output logic            mem_write,
  output logic            branch,
  output logic            branch_neq,
  output logic            jump,
  output logic            halt,
  output cpu_pkg::wbsrc_t wb_src,
  output cpu_pkg::word_t  imm_ext
);
  import cpu_pkg::*;

  opcode_t op;
  funct_t  fn;

  assign op = opcode_t'(instr[31:26]);
  assign fn = funct_t'(instr[5:0]);

  always_comb begin
    // defaults decode as a no-op
    alu_op      = ALU_ADD;
    alu_src_imm = 1'b0;
    shift_src   = 1'b0;
    reg_dst_rd  = 1'b0;
    reg_write   = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    branch      = 1'b0;
    branch_neq  = 1'b0;
    jump        = 1'b0;
    halt        = 1'b0;
    wb_src      = WB_ALU;
    imm_ext     = {{16{instr[15]}}, instr[15:0]};

    case (op)
      RTYPE: begin
        reg_dst_rd = 1'b1;
        reg_write  = 1'b1;
        imm_ext    = {27'b0, instr[10:6]};  // shamt rides in the immediate
        case (fn)
          SLL: begin
            alu_op    = ALU_SLL;
            shift_src = 1'b1;
          end
          ADDU:    alu_op = ALU_ADD;
          SUBU:    alu_op = ALU_SUB;
          AND:     alu_op = ALU_AND;
          OR:      alu_op = ALU_OR;
          SLT:     alu_op = ALU_SLT;
          default: reg_write = 1'b0;
        endcase
      end
      ADDIU: begin
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
      end
      ORI: begin
        alu_op      = ALU_OR;
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        imm_ext     = {16'b0, instr[15:0]};
      end
      LUI: begin
        alu_op      = ALU_OR;  // rs is r0
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        imm_ext     = {instr[15:0], 16'b0};
      end
      LW: begin
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        mem_read    = 1'b1;
        wb_src      = WB_MEM;
      end
      SW: begin
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      BEQ:     branch = 1'b1;
      BNE: begin
        branch     = 1'b1;
        branch_neq = 1'b1;
      end
      J:       jump = 1'b1;
      HALT:    halt = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: register_file.sv
/*
  32x32 register file, two read ports and one write port
  r0 reads zero, reads see a same-cycle write
*/
module register_file (
  input logic CLK,
  input logic nRST,
  register_file_if.rf rfif
);
  import cpu_pkg::*;

  word_t regs [31:1];  // no storage for r0

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rfif.wen && rfif.wsel != '0) begin
      regs[rfif.wsel] <= rfif.wdat;
    end
  end

  // bypass the write port so decode sees wb results
  always_comb begin
    if (rfif.rsel1 == '0) rfif.rdat1 = '0;
    else if (rfif.wen && rfif.wsel == rfif.rsel1) rfif.rdat1 = rfif.wdat;
    else rfif.rdat1 = regs[rfif.rsel1];

    if (rfif.rsel2 == '0) rfif.rdat2 = '0;
    else if (rfif.wen && rfif.wsel == rfif.rsel2) rfif.rdat2 = rfif.wdat;
    else rfif.rdat2 = regs[rfif.rsel2];
  end

  a_wdat_known: assert property (@(posedge CLK) disable iff (!nRST)
    rfif.wen |-> !$isunknown(rfif.wdat));

endmodule

// File: cpu_ifs.sv
/*
  register file, forwarding unit and hazard unit interfaces
*/
interface register_file_if;
  import cpu_pkg::*;

  regbits_t rsel1, rsel2, wsel;
  logic     wen;
  word_t    wdat, rdat1, rdat2;

  modport rf (input rsel1, rsel2, wen, wsel, wdat, output rdat1, rdat2);
  modport dp (output rsel1, rsel2, wen, wsel, wdat, input rdat1, rdat2);
endinterface

interface forward_unit_if;
  import cpu_pkg::*;

  regbits_t ex_rs, ex_rt;
  regbits_t mem_rd, wb_rd;
  logic     mem_reg_write, wb_reg_write;
  fwdsel_t  fwd_a, fwd_b;

  modport fu (input ex_rs, ex_rt, mem_rd, mem_reg_write, wb_rd, wb_reg_write,
              output fwd_a, fwd_b);
  modport dp (output ex_rs, ex_rt, mem_rd, mem_reg_write, wb_rd, wb_reg_write,
              input fwd_a, fwd_b);
endinterface

interface hazard_unit_if;
  import cpu_pkg::*;

  regbits_t id_rs, id_rt, ex_rd, mem_rd;
  logic     id_branch, id_branch_neq, id_jump, is_equal;
  logic     ex_mem_read, ex_reg_write, mem_reg_write;
  logic     pc_en, ifid_en, flush_ifid, flush_idex;

  modport hu (input id_rs, id_rt, id_branch, id_branch_neq, id_jump, is_equal,
              input ex_mem_read, ex_reg_write, ex_rd, mem_reg_write, mem_rd,
              output pc_en, ifid_en, flush_ifid, flush_idex);
  modport dp (output id_rs, id_rt, id_branch, id_branch_neq, id_jump, is_equal,
              output ex_mem_read, ex_reg_write, ex_rd, mem_reg_write, mem_rd,
              input pc_en, ifid_en, flush_ifid, flush_idex);
endinterface

// File: cpu_pkg.sv
/*
  shared types for the pipelined core
  word and register index types, opcode and function enums,
  alu operation, writeback and forward select enums, reset pc
*/
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // r-type function codes, instr[5:0]
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_SLL,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } aluop_t;

  typedef enum logic {
    WB_ALU,
    WB_MEM
  } wbsrc_t;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,  // from ex/mem alu result
    FWD_WB    // from writeback mux
  } fwdsel_t;

  localparam word_t PC_INIT = 32'h0000_0000;

endpackage
